// ==== hw/ci_defines.svh ====
`ifndef CI_DEFINES_SVH
`define CI_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Custom instruction interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CI_WORD_WIDTH 32
`define CI_ID_WIDTH 8

`define CI_ID_PROFILE 8
`define CI_ID_GRAYSCALE 12

// Top bit of the counter ends reset
`define RESET_COUNT_WIDTH 5

// Luminance weights, they add up to 256
`define GRAY_RED_WEIGHT 54
`define GRAY_GREEN_WEIGHT 183
`define GRAY_BLUE_WEIGHT 19

`endif

// ==== hw/or1420CiPkg.sv ====
`include "ci_defines.svh"

package or1420CiPkg;

  // Request as issued by the processor
  typedef struct packed {
    logic                      start;
    logic [`CI_ID_WIDTH-1:0]   id;
    logic [`CI_WORD_WIDTH-1:0] dataA;
    logic [`CI_WORD_WIDTH-1:0] dataB;
  } ciRequestT;

  // Result must be zero whenever done is low
  typedef struct packed {
    logic                      done;
    logic [`CI_WORD_WIDTH-1:0] result;
  } ciResponseT;

  // Weighted colour products between the two grayscale stages
  typedef struct packed {
    logic        valid;
    logic [15:0] redProduct;
    logic [15:0] greenProduct;
    logic [15:0] blueProduct;
  } grayPartialT;

endpackage

// ==== hw/ciStage.sv ====
`timescale 1ns/10ps

module ciStage #(
  parameter type payloadT = or1420CiPkg::ciResponseT
) (
  input  logic    s_systemClock,
  input  logic    s_pllLocked,
  input  logic    clear,
  input  payloadT d,
  output payloadT q
);

  // Synchronous clear flushes anything in flight
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      q <= '0;
    end else if (clear) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

// ==== hw/resetSequencer.sv ====
`timescale 1ns/10ps
`include "ci_defines.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset,
  output logic camnReset
);

  logic [`RESET_COUNT_WIDTH-1:0] resetCount;
  logic                          resetDone;

  assign resetDone = resetCount[`RESET_COUNT_WIDTH-1];

  // Count up after lock and hold once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetDone) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign camnReset = resetDone;
  assign cpuReset  = ~resetDone;

endmodule

// ==== hw/grayscaleCi.sv ====
`timescale 1ns/10ps
`include "ci_defines.svh"

module grayscaleCi (
  input  logic                    s_systemClock,
  input  logic                    s_pllLocked,
  input  logic                    cpuReset,
  input  or1420CiPkg::ciRequestT  request,
  output or1420CiPkg::ciResponseT response
);

  import or1420CiPkg::*;

  logic        isGrayscale;
  logic [7:0]  red8;
  logic [7:0]  green8;
  logic [7:0]  blue8;
  grayPartialT partialNext;
  grayPartialT partial;
  logic [15:0] graySum;
  ciResponseT  responseNext;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage one
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign isGrayscale = request.start && (request.id == `CI_ID_WIDTH'(`CI_ID_GRAYSCALE));

  // RGB565 fields widened to 8 bits
  assign red8   = {request.dataA[15:11], 3'b000};
  assign green8 = {request.dataA[10:5], 2'b00};
  assign blue8  = {request.dataA[4:0], 3'b000};

  always_comb begin
    partialNext = '0;
    if (isGrayscale) begin
      partialNext.valid        = 1'b1;
      partialNext.redProduct   = {8'd0, red8} * 16'(`GRAY_RED_WEIGHT);
      partialNext.greenProduct = {8'd0, green8} * 16'(`GRAY_GREEN_WEIGHT);
      partialNext.blueProduct  = {8'd0, blue8} * 16'(`GRAY_BLUE_WEIGHT);
    end
  end

  ciStage #(
    .payloadT(grayPartialT)
  ) partialStage (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .clear        (cpuReset),
    .d            (partialNext),
    .q            (partial)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage two
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Largest possible sum still fits in 16 bits
  assign graySum = partial.redProduct + partial.greenProduct + partial.blueProduct;

  always_comb begin
    responseNext = '0;
    if (partial.valid) begin
      responseNext.done   = 1'b1;
      responseNext.result = {{(`CI_WORD_WIDTH - 8){1'b0}}, graySum[15:8]};
    end
  end

  ciStage #(
    .payloadT(ciResponseT)
  ) responseStage (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .clear        (cpuReset),
    .d            (responseNext),
    .q            (response)
  );

endmodule

// ==== hw/profileCi.sv ====
`timescale 1ns/10ps
`include "ci_defines.svh"

module profileCi (
  input  logic                    s_systemClock,
  input  logic                    s_pllLocked,
  input  logic                    cpuReset,
  input  logic                    stall,
  input  logic                    busIdle,
  input  or1420CiPkg::ciRequestT  request,
  output or1420CiPkg::ciResponseT response
);

  import or1420CiPkg::*;

  logic                           isProfile;
  logic [2:0]                     enableMask;
  logic [2:0]                     countEvent;
  logic [2:0]                     clearMask;
  logic [2:0][`CI_WORD_WIDTH-1:0] counters;
  ciResponseT                     responseNext;

  assign isProfile = request.start && (request.id == `CI_ID_WIDTH'(`CI_ID_PROFILE));

  // Counter 0 cycles, counter 1 stalls, counter 2 bus idle
  assign countEvent = {busIdle, stall, 1'b1};
  assign clearMask  = isProfile ? request.dataB[10:8] : 3'b000;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Enable mask and counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      enableMask <= '0;
    end else if (cpuReset) begin
      enableMask <= '0;
    end else if (isProfile) begin
      enableMask <= request.dataB[2:0];
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      counters <= '0;
    end else if (cpuReset) begin
      counters <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (clearMask[i]) begin
          counters[i] <= '0;
        end else if (enableMask[i] && countEvent[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read back
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Value seen before the clear at the same edge
  always_comb begin
    responseNext = '0;
    if (isProfile) begin
      responseNext.done = 1'b1;
      case (request.dataA[1:0])
        2'd0:    responseNext.result = counters[0];
        2'd1:    responseNext.result = counters[1];
        2'd2:    responseNext.result = counters[2];
        default: responseNext.result = '0;
      endcase
    end
  end

  ciStage #(
    .payloadT(ciResponseT)
  ) responseStage (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .clear        (cpuReset),
    .d            (responseNext),
    .q            (response)
  );

endmodule

// ==== hw/ciResultMerge.sv ====
`timescale 1ns/10ps

module ciResultMerge (
  input  logic                    s_systemClock,
  input  logic                    s_pllLocked,
  input  logic                    cpuReset,
  input  or1420CiPkg::ciResponseT grayResponse,
  input  or1420CiPkg::ciResponseT profileResponse,
  output or1420CiPkg::ciResponseT response,
  output logic                    ciConflict
);

  import or1420CiPkg::*;

  ciResponseT mergedResponse;

  // Idle units drive zero, so a plain OR is enough
  assign mergedResponse.done   = grayResponse.done | profileResponse.done;
  assign mergedResponse.result = grayResponse.result | profileResponse.result;

  ciStage #(
    .payloadT(ciResponseT)
  ) mergeStage (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .clear        (cpuReset),
    .d            (mergedResponse),
    .q            (response)
  );

  // Two done strobes in one cycle corrupt the result
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      ciConflict <= 1'b0;
    end else if (cpuReset) begin
      ciConflict <= 1'b0;
    end else begin
      ciConflict <= grayResponse.done & profileResponse.done;
    end
  end

endmodule

// ==== hw/or1420CiTop.sv ====
`timescale 1ns/10ps

module or1420CiTop (
  input  logic                    s_systemClock,
  input  logic                    s_pllLocked,
  input  logic                    stall,
  input  logic                    busIdle,
  input  or1420CiPkg::ciRequestT  request,
  output or1420CiPkg::ciResponseT response,
  output logic                    camnReset,
  output logic                    ciConflict
);

  import or1420CiPkg::*;

  logic       cpuReset;
  ciResponseT grayResponse;
  ciResponseT profileResponse;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Power-up reset
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  resetSequencer resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset),
    .camnReset    (camnReset)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Custom instructions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ID 12
  grayscaleCi grayscale (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset),
    .request      (request),
    .response     (grayResponse)
  );

  // ID 8
  profileCi profile (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset),
    .stall        (stall),
    .busIdle      (busIdle),
    .request      (request),
    .response     (profileResponse)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response back to the processor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  ciResultMerge merge (
    .s_systemClock  (s_systemClock),
    .s_pllLocked    (s_pllLocked),
    .cpuReset       (cpuReset),
    .grayResponse   (grayResponse),
    .profileResponse(profileResponse),
    .response       (response),
    .ciConflict     (ciConflict)
  );

endmodule

// ==== tests/or1420Ci_checker.sv ====
`timescale 1ns/10ps
`include "ci_defines.svh"

module or1420Ci_checker (
  input logic                    s_systemClock,
  input logic                    s_pllLocked,
  input logic                    cpuReset,
  input or1420CiPkg::ciRequestT  request,
  input or1420CiPkg::ciResponseT response,
  input logic                    camnReset,
  input logic                    ciConflict
);

  import or1420CiPkg::*;

  int   failCount = 0;
  logic grayStart;
  logic profileStart;

  // Luminance of one RGB565 pixel, fields widened to 8 bits
  function automatic logic [7:0] grayOf(input logic [15:0] pixel);
    int weighted;
    weighted = int'({pixel[15:11], 3'b000}) * `GRAY_RED_WEIGHT
             + int'({pixel[10:5], 2'b00}) * `GRAY_GREEN_WEIGHT
             + int'({pixel[4:0], 3'b000}) * `GRAY_BLUE_WEIGHT;
    return 8'(weighted >> 8);
  endfunction

  // Starts that reach a unit, outside processor reset
  assign grayStart    = request.start && !cpuReset &&
                        (request.id == `CI_ID_WIDTH'(`CI_ID_GRAYSCALE));
  assign profileStart = request.start && !cpuReset &&
                        (request.id == `CI_ID_WIDTH'(`CI_ID_PROFILE));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response timing and value
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  grayResult: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    grayStart |-> ##3 (response.done &&
      response.result == `CI_WORD_WIDTH'(grayOf($past(request.dataA[15:0], 3)))))
    else begin
      failCount++;
      $error("grayscale response missing or wrong three cycles after start");
    end

  profileLatency: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    profileStart |-> ##2 response.done)
    else begin
      failCount++;
      $error("profile response missing two cycles after start");
    end

  doneSource: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    response.done |-> ($past(grayStart, 3) || $past(profileStart, 2)))
    else begin
      failCount++;
      $error("done pulse without a matching accepted start");
    end

  idleZero: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    !response.done |-> (response.result == '0))
    else begin
      failCount++;
      $error("result is not zero while done is low");
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reset and conflict
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  quietInReset: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    !camnReset |-> (!response.done && !ciConflict))
    else begin
      failCount++;
      $error("activity on the response while reset is held");
    end

  // Released on the 16th edge after lock
  releaseTime: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    $rose(camnReset) |-> ($past(s_pllLocked, 16) && !$past(s_pllLocked, 17)))
    else begin
      failCount++;
      $error("camera reset released at the wrong clock after lock");
    end

  resetHold: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    camnReset |=> camnReset)
    else begin
      failCount++;
      $error("camera reset dropped again while the PLL stayed locked");
    end

  noConflict: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    !ciConflict)
    else begin
      failCount++;
      $error("two unit responses arrived in the same cycle");
    end

endmodule

// ==== tests/or1420CiTb.sv ====
`timescale 1ns/10ps
`include "ci_defines.svh"

module or1420CiTb;

  import or1420CiPkg::*;

  localparam int RESET_RELEASE_EDGES = 16;
  localparam int GRAY_OPS = 24;
  localparam int PROFILE_OPS = 12;
  localparam int MAX_INTERVAL = 32;
  localparam int DONE_WAIT = 8;
  localparam int TIMEOUT_CYCLES = 4 + RESET_RELEASE_EDGES + GRAY_OPS * 6
                                + PROFILE_OPS * (MAX_INTERVAL + 6) + 64;

  logic                     s_systemClock;
  logic                     s_pllLocked;
  logic                     stall;
  logic                     busIdle;
  ciRequestT                request;
  ciResponseT               response;
  logic                     camnReset;
  logic                     ciConflict;

  int                       errorCount = 0;
  int                       cycleCount = 0;
  int                       lockEdges;
  logic [2:0]               modelEnable;
  logic [2:0]               modelClear;
  logic [2:0]               modelEvent;
  logic [2:0][31:0]         modelCount;

  or1420CiTop DUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .stall        (stall),
    .busIdle      (busIdle),
    .request      (request),
    .response     (response),
    .camnReset    (camnReset),
    .ciConflict   (ciConflict)
  );

  bind or1420CiTop or1420Ci_checker ciChecker (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset),
    .request      (request),
    .response     (response),
    .camnReset    (camnReset),
    .ciConflict   (ciConflict)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #5 s_systemClock = ~s_systemClock;
  end

  always @(posedge s_systemClock) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Counter model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockEdges   <= 0;
      modelEnable <= '0;
      modelCount  <= '0;
    end else if (lockEdges < RESET_RELEASE_EDGES) begin
      lockEdges   <= lockEdges + 1;
      modelEnable <= '0;
      modelCount  <= '0;
    end else begin
      modelClear = 3'b000;
      modelEvent = {busIdle, stall, 1'b1};
      if (request.start && request.id == `CI_ID_WIDTH'(`CI_ID_PROFILE)) begin
        modelEnable <= request.dataB[2:0];
        modelClear  = request.dataB[10:8];
      end
      for (int i = 0; i < 3; i++) begin
        if (modelClear[i]) begin
          modelCount[i] <= '0;
        end else if (modelEnable[i] && modelEvent[i]) begin
          modelCount[i] <= modelCount[i] + 1;
        end
      end
    end
  end

  // New random stall and bus-idle levels on every falling edge
  task automatic nextCycle();
    logic [31:0] randomBits;
    @(negedge s_systemClock);
    randomBits = $urandom();
    stall      = randomBits[0];
    busIdle    = randomBits[1];
  endtask

  task automatic idleCycles(input int count);
    repeat (count) nextCycle();
  endtask

  task automatic waitForDone(input string what, output logic seen);
    int waited;
    waited = 0;
    while (!response.done && waited < DONE_WAIT) begin
      nextCycle();
      waited++;
    end
    seen = response.done;
    assert (seen) else begin
      errorCount++;
      $display("No done pulse for the %s within %0d cycles", what, DONE_WAIT);
    end
  endtask

  task automatic grayscaleOp();
    logic seen;
    nextCycle();
    request       = '0;
    request.start = 1'b1;
    request.id    = `CI_ID_WIDTH'(`CI_ID_GRAYSCALE);
    request.dataA = $urandom();
    nextCycle();
    request = '0;
    waitForDone("grayscale instruction", seen);
  endtask

  task automatic profileRead(input logic [1:0] select, input logic [31:0] control,
                             output logic [31:0] value);
    logic [31:0] expected;
    logic        seen;
    nextCycle();
    request            = '0;
    request.start      = 1'b1;
    request.id         = `CI_ID_WIDTH'(`CI_ID_PROFILE);
    request.dataA      = $urandom();
    request.dataA[1:0] = select;
    request.dataB      = control;
    expected           = (select == 2'd3) ? 32'd0 : modelCount[select];
    nextCycle();
    request = '0;
    waitForDone("profile instruction", seen);
    value = response.result;
    if (seen) begin
      assert (value == expected) else begin
        errorCount++;
        $display("ERROR response.result (counter %0d) expected 0x%08h actual 0x%08h",
                 select, expected, value);
      end
    end
  endtask

  initial begin
    logic [31:0] value;
    logic [31:0] heldExpected;
    logic [31:0] heldBefore;
    logic [31:0] heldAfter;
    logic        seen;
    int          edgesAfterLock;
    int          totalErrors;

    s_pllLocked = 1'b0;
    stall       = 1'b0;
    busIdle     = 1'b0;
    request     = '0;
    void'($urandom(32'hbb4f_18a4));

    // Lock arrives after four cycles
    // Starts inside the release window must be ignored
    idleCycles(4);
    s_pllLocked    = 1'b1;
    edgesAfterLock = 0;
    while (!camnReset && edgesAfterLock < 2 * RESET_RELEASE_EDGES) begin
      nextCycle();
      edgesAfterLock++;
      assert (!response.done && !ciConflict) else begin
        errorCount++;
        $display("Response activity while the reset sequence was still running");
      end
      request = '0;
      if (edgesAfterLock == 2) begin
        request.start = 1'b1;
        request.id    = `CI_ID_WIDTH'(`CI_ID_GRAYSCALE);
        request.dataA = $urandom();
      end else if (edgesAfterLock == 3) begin
        request.start = 1'b1;
        request.id    = `CI_ID_WIDTH'(`CI_ID_PROFILE);
        request.dataB = 32'h0000_0707;
      end
    end
    assert (edgesAfterLock == RESET_RELEASE_EDGES) else begin
      errorCount++;
      $display("ERROR camnReset release edge expected 0x%02h actual 0x%02h",
               RESET_RELEASE_EDGES, edgesAfterLock);
    end

    repeat (GRAY_OPS) grayscaleOp();

    // Back to back grayscale starts
    nextCycle();
    request.start = 1'b1;
    request.id    = `CI_ID_WIDTH'(`CI_ID_GRAYSCALE);
    request.dataA = $urandom();
    nextCycle();
    request.dataA = $urandom();
    nextCycle();
    request = '0;
    waitForDone("first pipelined grayscale instruction", seen);
    nextCycle();
    assert (response.done) else begin
      errorCount++;
      $display("Second pipelined grayscale done did not follow the first one");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Profiling counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    profileRead(2'd3, 32'h0000_0707, value);
    for (int sel = 0; sel < 3; sel++) begin
      idleCycles(1 + ($urandom() % MAX_INTERVAL));
      profileRead(2'(sel), 32'h0000_0007, value);
    end
    profileRead(2'd1, 32'h0000_0207, value);
    idleCycles(1 + ($urandom() % MAX_INTERVAL));
    profileRead(2'd1, 32'h0000_0007, value);
    // Counter 2 stops here and keeps its last count
    profileRead(2'd2, 32'h0000_0003, value);
    heldExpected = modelCount[2];
    idleCycles(1 + ($urandom() % MAX_INTERVAL));
    profileRead(2'd2, 32'h0000_0003, heldBefore);
    idleCycles(1 + ($urandom() % MAX_INTERVAL));
    profileRead(2'd2, 32'h0000_0003, heldAfter);
    assert (heldBefore == heldExpected) else begin
      errorCount++;
      $display("ERROR response.result (disabled counter 2) expected 0x%08h actual 0x%08h",
               heldExpected, heldBefore);
    end
    assert (heldAfter == heldExpected) else begin
      errorCount++;
      $display("ERROR response.result (disabled counter 2) expected 0x%08h actual 0x%08h",
               heldExpected, heldAfter);
    end
    profileRead(2'd0, 32'h0000_0003, value);

    // Unused IDs must stay silent
    nextCycle();
    request.start = 1'b1;
    request.id    = 8'h05;
    request.dataA = $urandom();
    nextCycle();
    request.id = 8'h0d;
    nextCycle();
    request = '0;
    repeat (6) begin
      assert (!response.done) else begin
        errorCount++;
        $display("Done pulse seen after a start with an unused instruction ID");
      end
      nextCycle();
    end

    idleCycles(4);
    totalErrors = errorCount + DUT.ciChecker.failCount;
    $display("Error counts: testbench %0d, assertions %0d", errorCount,
             DUT.ciChecker.failCount);
    if (totalErrors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+hw
hw/or1420CiPkg.sv
hw/ciStage.sv
hw/resetSequencer.sv
hw/grayscaleCi.sv
hw/profileCi.sv
hw/ciResultMerge.sv
hw/or1420CiTop.sv
tests/or1420Ci_checker.sv
tests/or1420CiTb.sv

// ==== Bender.yml ====
package:
  name: or1420Ci

sources:
  - include_dirs:
      - hw
    files:
      - hw/or1420CiPkg.sv
      - hw/ciStage.sv
      - hw/resetSequencer.sv
      - hw/grayscaleCi.sv
      - hw/profileCi.sv
      - hw/ciResultMerge.sv
      - hw/or1420CiTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/or1420Ci_checker.sv
      - tests/or1420CiTb.sv
